// ==== atari5200Bus.f ====
rtl/consoleBusPkg.sv
rtl/busDecode.sv
rtl/workRam.sv
rtl/chipRegisters.sv
rtl/readResult.sv
rtl/consoleBus.sv
testbench/consoleBus_checker.sv
testbench/consoleBusTb.sv

// ==== testbench/consoleBusTb.sv ====
// Random traffic from xorshift seed 53; RAM is only read at indices the model has written
`timescale 1ns/1ps
`default_nettype none

module consoleBusTb;

    localparam int NumRandom = 600;
    localparam int DrainLimit = 8;
    localparam logic [31:0] Seed = 32'd53;

    // Region codes of the reference model
    localparam int MRam = 0;
    localparam int MCart = 1;
    localparam int MChip = 2;
    localparam int MOpen = 3;

    logic        request;
    logic        nRES_L;
    logic [15:0] cpuAddr;
    logic [7:0]  cpuWriteData;
    logic        cpuWrite;
    logic        cpuRead;
    logic [7:0]  cartData;
    logic [7:0]  readData;
    logic        readValid;
    logic [13:0] cartAddr;
    logic        cartSelLow;
    logic        cartSelHigh;
    logic [7:0]  audf1, audc1, audf2, audc2, audf3, audc3, audf4, audc4, audctl;
    logic [7:0]  colpm0, colpm1, colpm2, colpm3, colpf0, colpf1, colpf2, colpf3, colbk;
    logic [17:0][7:0] regPorts;

    logic [7:0]  ramModel [1024];
    logic        ramWritten [1024];
    logic [7:0]  regModel [18];
    logic [7:0]  expQ [$];
    logic [31:0] rngState;
    int          mismatches;
    int          timeouts;

    consoleBus i_consoleBus (.*);

    // Slots in offset order, AUDF1 AUDC1 .. AUDCTL then COLPM0 .. COLBK
    assign regPorts = {colbk, colpf3, colpf2, colpf1, colpf0, colpm3, colpm2, colpm1, colpm0,
                       audctl, audc4, audf4, audc3, audf3, audc2, audf2, audc1, audf1};

    always #5 request = ~request;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int regionOf(input logic [15:0] addr);
        if (addr < 16'h4000) return MRam;
        if (addr < 16'hC000) return MCart;
        if (addr[15:8] == 8'hC0 || addr[15:8] == 8'hE8) return MChip;
        return MOpen;
    endfunction

    // -1 for offsets with no register behind them
    function automatic int slotOf(input logic [15:0] addr);
        if (addr[15:8] == 8'hE8 && addr[3:0] <= 4'h8) return int'(addr[3:0]);
        if (addr[15:8] == 8'hC0 && addr[4:0] >= 5'h12 && addr[4:0] <= 5'h1A) begin
            return int'(addr[4:0]) - 9;
        end
        return -1;
    endfunction

    function automatic logic [7:0] modelRead(input logic [15:0] addr, input logic [7:0] cdata);
        int slot;
        slot = slotOf(addr);
        case (regionOf(addr))
            MRam:    return ramModel[addr[9:0]];
            MCart:   return cdata;
            MChip:   return (slot < 0) ? 8'hFF : regModel[slot];
            default: return 8'hFF;
        endcase
    endfunction

    task automatic modelWrite(input logic [15:0] addr, input logic [7:0] data);
        int slot;
        slot = slotOf(addr);
        if (regionOf(addr) == MRam) begin
            ramModel[addr[9:0]] = data;
            ramWritten[addr[9:0]] = 1'b1;
        end else if (slot >= 0) begin
            regModel[slot] = data;
        end
    endtask

    task automatic checkResult();
        logic [7:0] expected;
        if (expQ.size() > 0) begin
            expected = expQ.pop_front();
            if (readValid !== 1'b1 || readData !== expected) begin
                mismatches++;
                $display("MISMATCH at %0t: read valid=%b data=%h, expected %h",
                         $time, readValid, readData, expected);
            end
        end else if (readValid !== 1'b0) begin
            mismatches++;
            $display("MISMATCH at %0t: readValid high with no read pending", $time);
        end
        for (int s = 0; s < 18; s++) begin
            if (regPorts[s] !== regModel[s]) begin
                mismatches++;
                $display("MISMATCH at %0t: register slot %0d is %h, expected %h",
                         $time, s, regPorts[s], regModel[s]);
            end
        end
    endtask

    // Low bank is the 01 quarter of the map, high bank the 10 quarter
    task automatic checkCartPins(input logic [15:0] addr);
        logic expLow;
        logic expHigh;
        expLow = (addr[15:14] != 2'b01);
        expHigh = (addr[15:14] != 2'b10);
        if (cartAddr !== addr[13:0] || cartSelLow !== expLow || cartSelHigh !== expHigh) begin
            mismatches++;
            $display("MISMATCH at %0t: cart pins %h/%b/%b for address %h",
                     $time, cartAddr, cartSelLow, cartSelHigh, addr);
        end
    endtask

    // One bus cycle, driven at the falling edge after checking the previous one
    task automatic busCycle(input logic [15:0] addr, input logic [7:0] wdata,
                            input logic wr, input logic rd, input logic [7:0] cdata);
        @(negedge request);
        checkResult();
        cpuAddr = addr;
        cpuWriteData = wdata;
        cpuWrite = wr;
        cpuRead = rd;
        cartData = cdata;
        if (rd) expQ.push_back(modelRead(addr, cdata));
        if (wr) modelWrite(addr, wdata);
        #1;
        checkCartPins(addr);
    endtask

    task automatic writeBus(input logic [15:0] addr, input logic [7:0] data);
        busCycle(addr, data, 1'b1, 1'b0, 8'h00);
    endtask

    task automatic readBus(input logic [15:0] addr, input logic [7:0] cdata);
        busCycle(addr, 8'h00, 1'b0, 1'b1, cdata);
    endtask

    task automatic randomCycle();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [15:0] addr;
        logic        wr;
        logic        rd;
        rngState = xorshift(rngState);
        r1 = rngState;
        rngState = xorshift(rngState);
        r2 = rngState;
        // Mostly RAM, cartridge and the two chip pages
        case (r1[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: addr = {2'b00, r1[29:16]};
            4'd5, 4'd6, 4'd7:             addr = 16'h4000 + {1'b0, r1[30:16]};
            4'd8, 4'd9:                   addr = {8'hC0, r1[23:16]};
            4'd10, 4'd11:                 addr = {8'hE8, r1[23:16]};
            4'd12:                        addr = {8'hD4, r1[23:16]};
            4'd13:                        addr = {5'b11111, r1[26:16]};
            default:                      addr = {2'b11, r1[29:16]};
        endcase
        rd = (r2[1:0] != 2'b00);
        wr = r2[2];
        if (rd && regionOf(addr) == MRam && !ramWritten[addr[9:0]]) begin
            rd = 1'b0;
            wr = 1'b1;
        end
        busCycle(addr, r2[15:8], wr, rd, r2[23:16]);
    endtask

    initial begin
        request = 1'b0;
        nRES_L = 1'b1;
        cpuAddr = '0;
        cpuWriteData = '0;
        cpuWrite = 1'b0;
        cpuRead = 1'b0;
        cartData = '0;
        mismatches = 0;
        timeouts = 0;
        rngState = Seed;
        for (int i = 0; i < 18; i++) regModel[i] = 8'h00;
        for (int i = 0; i < 1024; i++) ramWritten[i] = 1'b0;

        repeat (2) @(posedge request);
        @(negedge request);
        nRES_L = 1'b0;
        if (readValid !== 1'b0 || readData !== 8'h00) begin
            mismatches++;
            $display("MISMATCH at %0t: read port not idle after reset", $time);
        end

        for (int o = 0; o < 9; o++) readBus(16'hE800 + 16'(o), 8'h00);
        for (int o = 18; o < 27; o++) readBus(16'hC000 + 16'(o), 8'h00);

        // Aliases above bit 9 hit the same RAM word
        writeBus(16'h0123, 8'h5A);
        writeBus(16'h2523, 8'hA5);
        readBus(16'h0123, 8'h00);
        readBus(16'h3D23, 8'h00);

        for (int o = 0; o < 9; o++) begin
            writeBus(16'hE8F0 + 16'(o), 8'h10 + 8'(o));
            readBus(16'hE800 + 16'(o), 8'h00);
        end
        for (int o = 18; o < 27; o++) begin
            writeBus(16'hC0E0 + 16'(o), 8'h80 + 8'(o));
            readBus(16'hC000 + 16'(o), 8'h00);
        end
        writeBus(16'hE80C, 8'h77);
        readBus(16'hE80C, 8'h00);
        writeBus(16'hC005, 8'h77);
        readBus(16'hC005, 8'h00);

        readBus(16'h4000, 8'h11);
        readBus(16'h7FFF, 8'h22);
        readBus(16'h8000, 8'h33);
        readBus(16'hBFFF, 8'h44);

        // ANTIC, BIOS and other unmapped space, D400 shares its low bits with RAM word 0
        writeBus(16'h0000, 8'h69);
        writeBus(16'hD400, 8'h12);
        readBus(16'hD400, 8'h00);
        readBus(16'h0000, 8'h00);
        readBus(16'hF800, 8'h00);
        readBus(16'hFFFF, 8'h00);

        busCycle(16'h0123, 8'hC3, 1'b1, 1'b1, 8'h00);
        readBus(16'h0123, 8'h00);
        busCycle(16'hE800, 8'h3C, 1'b1, 1'b1, 8'h00);
        readBus(16'hE800, 8'h00);

        for (int i = 0; i < NumRandom; i++) randomCycle();

        for (int n = 0; n < DrainLimit && (expQ.size() != 0 || readValid); n++) begin
            busCycle(16'h0000, 8'h00, 1'b0, 1'b0, 8'h00);
        end
        if (expQ.size() != 0 || readValid) begin
            timeouts++;
            $display("Timeout: read results still pending after %0d idle cycles", DrainLimit);
        end

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/consoleBus_checker.sv ====
// Bound into consoleBus; assertions use the bus clock and ignore cycles held in reset
`timescale 1ns/1ps
`default_nettype none

module consoleBus_checker (
    input logic request,
    input logic nRES_L,
    input logic cpuRead,
    input logic readValid,
    input logic cartSelLow,
    input logic cartSelHigh
);

    // One result per read, exactly one cycle later
    readFollowsRequest: assert property (
        @(posedge request) disable iff (nRES_L)
        !$past(nRES_L) |-> (readValid == $past(cpuRead))
    ) else $error("readValid does not follow cpuRead by one cycle");

    // Only one cartridge bank at a time
    oneBankSelected: assert property (
        @(posedge request) cartSelLow || cartSelHigh
    ) else $error("both cartridge bank selects are low");

    readIdleAfterReset: assert property (
        @(posedge request) $fell(nRES_L) |-> !readValid
    ) else $error("readValid is high in the cycle after reset");

endmodule

bind consoleBus consoleBus_checker i_consoleBusChecker (
    .request     (request),
    .nRES_L      (nRES_L),
    .cpuRead     (cpuRead),
    .readValid   (readValid),
    .cartSelLow  (cartSelLow),
    .cartSelHigh (cartSelHigh)
);

`default_nettype wire

// ==== rtl/consoleBus.sv ====
// No back-pressure: every request is taken in its own cycle, reads answer one cycle later
`timescale 1ns/1ps
`default_nettype none

module consoleBus (
    input  logic                                   request,
    input  logic                                   nRES_L,
    input  consoleBusPkg::addrT                    cpuAddr,
    input  consoleBusPkg::dataT                    cpuWriteData,
    input  logic                                   cpuWrite,
    input  logic                                   cpuRead,
    input  consoleBusPkg::dataT                    cartData,
    output consoleBusPkg::dataT                    readData,
    output logic                                   readValid,
    output logic [consoleBusPkg::CartAddrBits-1:0] cartAddr,
    output logic                                   cartSelLow,
    output logic                                   cartSelHigh,
    output consoleBusPkg::dataT                    audf1,
    output consoleBusPkg::dataT                    audf2,
    output consoleBusPkg::dataT                    audf3,
    output consoleBusPkg::dataT                    audf4,
    output consoleBusPkg::dataT                    audc1,
    output consoleBusPkg::dataT                    audc2,
    output consoleBusPkg::dataT                    audc3,
    output consoleBusPkg::dataT                    audc4,
    output consoleBusPkg::dataT                    audctl,
    output consoleBusPkg::dataT                    colpm0,
    output consoleBusPkg::dataT                    colpm1,
    output consoleBusPkg::dataT                    colpm2,
    output consoleBusPkg::dataT                    colpm3,
    output consoleBusPkg::dataT                    colpf0,
    output consoleBusPkg::dataT                    colpf1,
    output consoleBusPkg::dataT                    colpf2,
    output consoleBusPkg::dataT                    colpf3,
    output consoleBusPkg::dataT                    colbk
);
    import consoleBusPkg::*;

    regionE                 region;
    chipRegE                chipReg;
    logic [RamAddrBits-1:0] ramIndex;
    dataT                   regReadData;
    dataT                   ramReadData;

    busDecode i_busDecode (
        .cpuAddr     (cpuAddr),
        .region      (region),
        .chipReg     (chipReg),
        .ramIndex    (ramIndex),
        .cartAddr    (cartAddr),
        .cartSelLow  (cartSelLow),
        .cartSelHigh (cartSelHigh)
    );

    chipRegisters i_chipRegisters (
        .request      (request),
        .nRES_L       (nRES_L),
        .cpuWrite     (cpuWrite),
        .cpuWriteData (cpuWriteData),
        .region       (region),
        .chipReg      (chipReg),
        .ramIndex     (ramIndex),
        .regReadData  (regReadData),
        .ramReadData  (ramReadData),
        .audf1        (audf1),
        .audf2        (audf2),
        .audf3        (audf3),
        .audf4        (audf4),
        .audc1        (audc1),
        .audc2        (audc2),
        .audc3        (audc3),
        .audc4        (audc4),
        .audctl       (audctl),
        .colpm0       (colpm0),
        .colpm1       (colpm1),
        .colpm2       (colpm2),
        .colpm3       (colpm3),
        .colpf0       (colpf0),
        .colpf1       (colpf1),
        .colpf2       (colpf2),
        .colpf3       (colpf3),
        .colbk        (colbk)
    );

    readResult i_readResult (
        .request     (request),
        .nRES_L      (nRES_L),
        .cpuRead     (cpuRead),
        .region      (region),
        .regReadData (regReadData),
        .ramReadData (ramReadData),
        .cartData    (cartData),
        .readData    (readData),
        .readValid   (readValid)
    );

endmodule

`default_nettype wire

// ==== rtl/readResult.sv ====
// Read data is valid only while readValid is high and otherwise holds the last result
`timescale 1ns/1ps
`default_nettype none

module readResult (
    input  logic                   request,
    input  logic                   nRES_L,
    input  logic                   cpuRead,
    input  consoleBusPkg::regionE  region,
    input  consoleBusPkg::dataT    regReadData,
    input  consoleBusPkg::dataT    ramReadData,
    input  consoleBusPkg::dataT    cartData,
    output consoleBusPkg::dataT    readData,
    output logic                   readValid
);
    import consoleBusPkg::*;

    regionE regionQ;
    dataT   regDataQ;
    dataT   cartDataQ;
    dataT   heldData;
    dataT   selData;

    always_ff @(posedge request or posedge nRES_L) begin
        if (nRES_L) begin
            readValid <= 1'b0;
        end else begin
            readValid <= cpuRead;
        end
    end

    // Capture the request-cycle payload
    always_ff @(posedge request) begin
        if (cpuRead) begin
            regionQ   <= region;
            regDataQ  <= regReadData;
            cartDataQ <= cartData;
        end
    end

    // RAM data is already one cycle late, so it is taken directly
    always_comb begin
        case (regionQ)
            RegionRam:               selData = ramReadData;
            RegionCart:              selData = cartDataQ;
            RegionGtia, RegionPokey: selData = regDataQ;
            default:                 selData = OpenBusData;
        endcase
    end

    always_ff @(posedge request or posedge nRES_L) begin
        if (nRES_L) begin
            heldData <= '0;
        end else if (readValid) begin
            heldData <= selData;
        end
    end

    assign readData = readValid ? selData : heldData;

endmodule

`default_nettype wire

// ==== rtl/chipRegisters.sv ====
// Chip registers read back their stored value; unused offsets in a chip page read as open bus
`timescale 1ns/1ps
`default_nettype none

module chipRegisters (
    input  logic                                  request,
    input  logic                                  nRES_L,
    input  logic                                  cpuWrite,
    input  consoleBusPkg::dataT                   cpuWriteData,
    input  consoleBusPkg::regionE                 region,
    input  consoleBusPkg::chipRegE                chipReg,
    input  logic [consoleBusPkg::RamAddrBits-1:0] ramIndex,
    output consoleBusPkg::dataT                   regReadData,
    output consoleBusPkg::dataT                   ramReadData,
    output consoleBusPkg::dataT                   audf1,
    output consoleBusPkg::dataT                   audf2,
    output consoleBusPkg::dataT                   audf3,
    output consoleBusPkg::dataT                   audf4,
    output consoleBusPkg::dataT                   audc1,
    output consoleBusPkg::dataT                   audc2,
    output consoleBusPkg::dataT                   audc3,
    output consoleBusPkg::dataT                   audc4,
    output consoleBusPkg::dataT                   audctl,
    output consoleBusPkg::dataT                   colpm0,
    output consoleBusPkg::dataT                   colpm1,
    output consoleBusPkg::dataT                   colpm2,
    output consoleBusPkg::dataT                   colpm3,
    output consoleBusPkg::dataT                   colpf0,
    output consoleBusPkg::dataT                   colpf1,
    output consoleBusPkg::dataT                   colpf2,
    output consoleBusPkg::dataT                   colpf3,
    output consoleBusPkg::dataT                   colbk
);
    import consoleBusPkg::*;

    dataT regFile [ChipRegCount];
    logic chipPage;
    logic regWrite;
    logic ramWrite;

    assign chipPage = (region == RegionGtia) || (region == RegionPokey);
    assign regWrite = cpuWrite && chipPage && (chipReg != RegNone);
    assign ramWrite = cpuWrite && (region == RegionRam);

    always_ff @(posedge request or posedge nRES_L) begin
        if (nRES_L) begin
            for (int i = 0; i < ChipRegCount; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWrite) begin
            regFile[chipReg] <= cpuWriteData;
        end
    end

    // Value before this cycle's write
    assign regReadData = (chipReg == RegNone) ? OpenBusData : regFile[chipReg];

    workRam i_workRam (
        .request   (request),
        .write     (ramWrite),
        .index     (ramIndex),
        .writeData (cpuWriteData),
        .readData  (ramReadData)
    );

    // Register values for the audio and video engines
    assign audf1  = regFile[RegAudf1];
    assign audf2  = regFile[RegAudf2];
    assign audf3  = regFile[RegAudf3];
    assign audf4  = regFile[RegAudf4];
    assign audc1  = regFile[RegAudc1];
    assign audc2  = regFile[RegAudc2];
    assign audc3  = regFile[RegAudc3];
    assign audc4  = regFile[RegAudc4];
    assign audctl = regFile[RegAudctl];
    assign colpm0 = regFile[RegColpm0];
    assign colpm1 = regFile[RegColpm1];
    assign colpm2 = regFile[RegColpm2];
    assign colpm3 = regFile[RegColpm3];
    assign colpf0 = regFile[RegColpf0];
    assign colpf1 = regFile[RegColpf1];
    assign colpf2 = regFile[RegColpf2];
    assign colpf3 = regFile[RegColpf3];
    assign colbk  = regFile[RegColbk];

endmodule

`default_nettype wire

// ==== rtl/workRam.sv ====
// Read-first single-port RAM; contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module workRam (
    input  logic                                  request,
    input  logic                                  write,
    input  logic [consoleBusPkg::RamAddrBits-1:0] index,
    input  consoleBusPkg::dataT                   writeData,
    output consoleBusPkg::dataT                   readData
);
    import consoleBusPkg::*;

    localparam int Depth = 2 ** RamAddrBits;

    dataT mem [Depth];

    always_ff @(posedge request) begin
        if (write) begin
            mem[index] <= writeData;
        end
    end

    // Old contents come out when the same word is written
    always_ff @(posedge request) begin
        readData <= mem[index];
    end

endmodule

`default_nettype wire

// ==== rtl/busDecode.sv ====
// Purely combinational; ANTIC and BIOS pages decode as unmapped, chip pages mirror on their low bits
`timescale 1ns/1ps
`default_nettype none

module busDecode (
    input  consoleBusPkg::addrT                         cpuAddr,
    output consoleBusPkg::regionE                       region,
    output consoleBusPkg::chipRegE                      chipReg,
    output logic [consoleBusPkg::RamAddrBits-1:0]       ramIndex,
    output logic [consoleBusPkg::CartAddrBits-1:0]      cartAddr,
    output logic                                        cartSelLow,
    output logic                                        cartSelHigh
);
    import consoleBusPkg::*;

    logic [7:0] page;

    assign page = cpuAddr[AddrBits-1:AddrBits-8];

    always_comb begin
        if (cpuAddr <= RamTop) begin
            region = RegionRam;
        end else if (cpuAddr >= CartBase && cpuAddr <= CartTop) begin
            region = RegionCart;
        end else if (page == GtiaPage) begin
            region = RegionGtia;
        end else if (page == PokeyPage) begin
            region = RegionPokey;
        end else begin
            region = RegionUnmapped;
        end
    end

    always_comb begin
        chipReg = RegNone;
        if (region == RegionGtia) begin
            // GTIA mirrors every 32 bytes
            case (cpuAddr[4:0])
                OffColpm0: chipReg = RegColpm0;
                OffColpm1: chipReg = RegColpm1;
                OffColpm2: chipReg = RegColpm2;
                OffColpm3: chipReg = RegColpm3;
                OffColpf0: chipReg = RegColpf0;
                OffColpf1: chipReg = RegColpf1;
                OffColpf2: chipReg = RegColpf2;
                OffColpf3: chipReg = RegColpf3;
                OffColbk:  chipReg = RegColbk;
                default:   chipReg = RegNone;
            endcase
        end else if (region == RegionPokey) begin
            // POKEY mirrors every 16 bytes
            case ({1'b0, cpuAddr[3:0]})
                OffAudf1:  chipReg = RegAudf1;
                OffAudc1:  chipReg = RegAudc1;
                OffAudf2:  chipReg = RegAudf2;
                OffAudc2:  chipReg = RegAudc2;
                OffAudf3:  chipReg = RegAudf3;
                OffAudc3:  chipReg = RegAudc3;
                OffAudf4:  chipReg = RegAudf4;
                OffAudc4:  chipReg = RegAudc4;
                OffAudctl: chipReg = RegAudctl;
                default:   chipReg = RegNone;
            endcase
        end
    end

    // 1 KiB RAM aliases across the whole 16 KiB window
    assign ramIndex = cpuAddr[RamAddrBits-1:0];

    assign cartAddr = cpuAddr[CartAddrBits-1:0];

    // Active-low bank selects
    assign cartSelLow  = !(cpuAddr >= CartBase && cpuAddr < CartHighBase);
    assign cartSelHigh = !(cpuAddr >= CartHighBase && cpuAddr <= CartTop);

endmodule

`default_nettype wire

// ==== rtl/consoleBusPkg.sv ====
// Memory map and register offsets follow the console map, but only the audio and colour registers exist
`default_nettype none

package consoleBusPkg;

    localparam int AddrBits     = 16;
    localparam int DataBits     = 8;
    localparam int RamAddrBits  = 10;
    localparam int CartAddrBits = 14;

    typedef logic [AddrBits-1:0] addrT;
    typedef logic [DataBits-1:0] dataT;

    // Region bounds
    localparam addrT RamTop       = 16'h3FFF;
    localparam addrT CartBase     = 16'h4000;
    localparam addrT CartHighBase = 16'h8000;
    localparam addrT CartTop      = 16'hBFFF;
    localparam logic [7:0] GtiaPage  = 8'hC0;
    localparam logic [7:0] PokeyPage = 8'hE8;

    localparam dataT OpenBusData = 8'hFF;

    // POKEY offsets, frequency and control interleaved
    localparam logic [4:0] OffAudf1  = 5'h00;
    localparam logic [4:0] OffAudc1  = 5'h01;
    localparam logic [4:0] OffAudf2  = 5'h02;
    localparam logic [4:0] OffAudc2  = 5'h03;
    localparam logic [4:0] OffAudf3  = 5'h04;
    localparam logic [4:0] OffAudc3  = 5'h05;
    localparam logic [4:0] OffAudf4  = 5'h06;
    localparam logic [4:0] OffAudc4  = 5'h07;
    localparam logic [4:0] OffAudctl = 5'h08;

    // GTIA colour offsets
    localparam logic [4:0] OffColpm0 = 5'h12;
    localparam logic [4:0] OffColpm1 = 5'h13;
    localparam logic [4:0] OffColpm2 = 5'h14;
    localparam logic [4:0] OffColpm3 = 5'h15;
    localparam logic [4:0] OffColpf0 = 5'h16;
    localparam logic [4:0] OffColpf1 = 5'h17;
    localparam logic [4:0] OffColpf2 = 5'h18;
    localparam logic [4:0] OffColpf3 = 5'h19;
    localparam logic [4:0] OffColbk  = 5'h1A;

    typedef enum logic [2:0] {
        RegionRam,
        RegionCart,
        RegionGtia,
        RegionPokey,
        RegionUnmapped
    } regionE;

    typedef enum logic [4:0] {
        RegAudf1, RegAudf2, RegAudf3, RegAudf4,
        RegAudc1, RegAudc2, RegAudc3, RegAudc4,
        RegAudctl,
        RegColpm0, RegColpm1, RegColpm2, RegColpm3,
        RegColpf0, RegColpf1, RegColpf2, RegColpf3,
        RegColbk,
        RegNone
    } chipRegE;

    // Number of real registers, everything before RegNone
    localparam int ChipRegCount = 18;

endpackage

`default_nettype wire
